// File: tb.f
+incdir+.
router_pkg.sv
alloc_if.sv
rr_arbiter.sv
input_port.sv
ovc_status.sv
vc_sw_alloc.sv
crossbar.sv
router_two_stage.sv
tb_router_checks.sv
tb_router.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary -f tb.f --top-module tb_router -o tb_router \
    && ./obj_dir/tb_router \
    || exit 1

// File: tb_router.sv
`timescale 1ns/1ps
`default_nettype none
`include "router_defs.svh"

module tb_router;
    localparam int P     = `ROUTER_P;
    localparam int V     = `ROUTER_V;
    localparam int S     = P * V;    // one source per input vc
    localparam int DEPTH = `ROUTER_BUF_DEPTH;
    localparam int N_PKT = 80;
    localparam int STALL = 60;
    localparam int LIMIT = N_PKT * 4 * P * 40 + STALL;

    logic              clk;
    logic              arst_n;
    router_pkg::flit_t flit_in [P];
    logic [P-1:0]      flit_wr_in;
    router_pkg::flit_t flit_out [P];
    logic [P-1:0]      flit_wr_out;
    logic [V-1:0]      credit_in [P];
    logic [V-1:0]      credit_out [P];
    logic              err_chk;

    logic [31:0]       rng = 32'h6765f705;
    int                cyc;
    logic              stall;
    router_pkg::flit_t src_q [S][$];     // generated, not yet written
    int                route_q [S][$];   // head route of each queued flit
    router_pkg::flit_t exp_q [P][S][$];
    int                exp_cyc [P][S][$];
    int                seq [S];
    int                tx_cred [S];
    int                written [S];
    int                returned [S];
    int                pend_ret [P][V];  // credits owed to the router
    int                wait_cnt [P][S];

    router_two_stage UUT (.*);

    tb_router_checks u_checks (
        .clk(clk), .arst_n(arst_n), .flit_out(flit_out), .flit_wr_out(flit_wr_out),
        .credit_in(credit_in), .credit_out(credit_out), .err(err_chk)
    );

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic fail_check(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic add_packet(input int p, input int v, input int dest, input int len);
        router_pkg::flit_t f;
        int s;
        s = p * V + v;
        for (int k = 0; k < len; k++) begin
            if (len == 1) f.ftype = router_pkg::FT_SINGLE;
            else if (k == 0) f.ftype = router_pkg::FT_HEAD;
            else if (k == len - 1) f.ftype = router_pkg::FT_TAIL;
            else f.ftype = router_pkg::FT_BODY;
            f.vc = router_pkg::vc_idx_t'(v);
            f.dest = router_pkg::port_idx_t'(dest + k);   // only the head route counts
            f.payload = {2'(p), 1'(v), 13'(seq[s])};   // source and sequence tag
            seq[s]++;
            src_q[s].push_back(f);
            route_q[s].push_back(dest);
        end
    endtask

    function automatic bit drained();
        for (int s = 0; s < S; s++) begin
            if (src_q[s].size() != 0) return 1'b0;
            for (int o = 0; o < P; o++) begin
                if (exp_q[o][s].size() != 0) return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic wait_drained();
        while (!drained()) @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    task automatic check_output(input int o, input router_pkg::flit_t f);
        router_pkg::flit_t e;
        int s;
        int w;
        s = int'(f.payload[15:13]);
        assert (exp_q[o][s].size() != 0)
            else fail_check($sformatf("port %0d got unexpected flit %h", o, f));
        e = exp_q[o][s].pop_front();
        w = exp_cyc[o][s].pop_front();
        assert (f.ftype == e.ftype && f.dest == e.dest && f.payload == e.payload)
            else fail_check($sformatf("port %0d got %h, expected %h", o, f, e));
        assert (cyc - w >= 2) else fail_check($sformatf("port %0d flit left too early", o));
        pend_ret[o][f.vc]++;
        if (f.ftype == router_pkg::FT_HEAD || f.ftype == router_pkg::FT_SINGLE) begin
            for (int k = 0; k < S; k++) begin
                if (k != s && exp_q[o][k].size() != 0) begin
                    wait_cnt[o][k]++;
                    assert (wait_cnt[o][k] <= P * 4)
                        else fail_check($sformatf("source %0d starved at port %0d", k, o));
                end
            end
            wait_cnt[o][s] = 0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // monitor first, then drive the next cycle
    always @(posedge clk) begin
        router_pkg::flit_t f;
        int s;
        int r;
        int v0;
        bit sent;
        cyc++;
        if (arst_n) begin
            for (int o = 0; o < P; o++) begin
                if (flit_wr_out[o]) check_output(o, flit_out[o]);
            end
            for (int p = 0; p < P; p++) begin
                for (int v = 0; v < V; v++) begin
                    if (credit_out[p][v]) begin
                        returned[p * V + v]++;
                        tx_cred[p * V + v]++;
                        assert (tx_cred[p * V + v] <= DEPTH)
                            else fail_check($sformatf("extra credit on port %0d vc %0d", p, v));
                    end
                end
            end
            for (int p = 0; p < P; p++) begin
                flit_wr_in[p] <= 1'b0;
                sent = 1'b0;
                v0 = int'(next_rand() % V);
                for (int k = 0; k < V; k++) begin
                    s = p * V + (v0 + k) % V;
                    if (!sent && src_q[s].size() != 0 && tx_cred[s] > 0) begin
                        f = src_q[s].pop_front();
                        r = route_q[s].pop_front();
                        flit_in[p] <= f;
                        flit_wr_in[p] <= 1'b1;
                        tx_cred[s]--;
                        written[s]++;
                        exp_q[r][s].push_back(f);
                        exp_cyc[r][s].push_back(cyc + 1);   // sampled next edge
                        sent = 1'b1;
                    end
                end
            end
            for (int o = 0; o < P; o++) begin
                for (int v = 0; v < V; v++) begin
                    credit_in[o][v] <= !stall && pend_ret[o][v] > 0;
                    if (!stall && pend_ret[o][v] > 0) pend_ret[o][v]--;
                end
            end
        end
    end

    initial begin
        #(LIMIT * 20);
        $display("watchdog expired before all traffic was delivered");
        $display("Something failed");
        $fatal(1);
    end

    always @(posedge err_chk) begin
        $display("Something failed");
        $fatal(1, "checker reported an error");
    end

    initial begin
        arst_n = 1'b1;
        flit_wr_in = '0;
        stall = 1'b0;
        cyc = 0;
        for (int p = 0; p < P; p++) begin
            flit_in[p] = '0;
            credit_in[p] = '0;
        end
        for (int s = 0; s < S; s++) begin
            seq[s] = 0;
            tx_cred[s] = DEPTH;
            written[s] = 0;
            returned[s] = 0;
            for (int o = 0; o < P; o++) wait_cnt[o][s] = 0;
        end
        for (int o = 0; o < P; o++) begin
            for (int v = 0; v < V; v++) pend_ret[o][v] = 0;
        end
        #1 arst_n = 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        // random traffic on all ports
        repeat (40) add_packet(int'(next_rand() % P), int'(next_rand() % V),
                               int'(next_rand() % P), 1 + int'(next_rand() % 4));
        wait_drained();

        // every source streams into port 0
        for (int p = 0; p < P; p++) begin
            for (int v = 0; v < V; v++) begin
                repeat (3) add_packet(p, v, 0, 4);
            end
        end
        wait_drained();

        // port 1 gets no credits back for a while
        stall <= 1'b1;
        for (int p = 0; p < P; p++) begin
            for (int v = 0; v < V; v++) begin
                repeat (2) add_packet(p, v, 1, 4);
            end
        end
        repeat (STALL) @(posedge clk);
        stall <= 1'b0;
        wait_drained();

        for (int s = 0; s < S; s++) begin
            assert (returned[s] == written[s])
                else fail_check($sformatf("source %0d wrote %0d got %0d credits",
                                          s, written[s], returned[s]));
        end
        if (!err_chk) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1);
        end
    end
endmodule

`default_nettype wire

// File: tb_router_checks.sv
`timescale 1ns/1ps
`default_nettype none
`include "router_defs.svh"

module tb_router_checks (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire router_pkg::flit_t    flit_out [`ROUTER_P],
    input  wire logic [`ROUTER_P-1:0] flit_wr_out,
    input  wire logic [`ROUTER_V-1:0] credit_in [`ROUTER_P],
    input  wire logic [`ROUTER_V-1:0] credit_out [`ROUTER_P],
    output logic                      err
);
    localparam int P     = `ROUTER_P;
    localparam int V     = `ROUTER_V;
    localparam int DEPTH = `ROUTER_BUF_DEPTH;

    logic err_q = 1'b0;
    int   since_rst;
    int   outstanding [P][V];   // flits sent minus credits returned
    int   open_src [P][V];      // -1 when no packet is open

    assign err = err_q;

    task automatic report(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        err_q = 1'b1;
    endtask

    always @(posedge clk) begin
        int src;
        int ov;
        if (!arst_n || since_rst < 2) begin
            assert (flit_wr_out == '0) else report("flit_wr_out high in or right after reset");
            for (int p = 0; p < P; p++) begin
                assert (credit_out[p] == '0) else report("credit_out high in or after reset");
            end
        end
        if (!arst_n) begin
            since_rst = 0;
            for (int o = 0; o < P; o++) begin
                for (int v = 0; v < V; v++) begin
                    outstanding[o][v] = 0;
                    open_src[o][v] = -1;
                end
            end
        end else begin
            since_rst++;
            for (int o = 0; o < P; o++) begin
                for (int v = 0; v < V; v++) begin
                    if (credit_in[o][v]) outstanding[o][v]--;
                end
                if (flit_wr_out[o]) begin
                    src = int'(flit_out[o].payload[15:13]);   // port and vc tag
                    ov = int'(flit_out[o].vc);
                    assert (!$isunknown(flit_out[o].vc))
                        else report($sformatf("port %0d vc field unknown", o));
                    outstanding[o][ov]++;
                    assert (outstanding[o][ov] <= DEPTH)
                        else report($sformatf("port %0d vc %0d sent beyond credits", o, ov));
                    case (flit_out[o].ftype)
                        router_pkg::FT_HEAD: begin
                            assert (open_src[o][ov] == -1)
                                else report($sformatf("head interleaved on port %0d", o));
                            open_src[o][ov] = src;
                        end
                        router_pkg::FT_BODY: begin
                            assert (open_src[o][ov] == src)
                                else report($sformatf("stray body on port %0d", o));
                        end
                        router_pkg::FT_TAIL: begin
                            assert (open_src[o][ov] == src)
                                else report($sformatf("stray tail on port %0d", o));
                            open_src[o][ov] = -1;
                        end
                        default: begin
                            assert (open_src[o][ov] == -1)
                                else report($sformatf("single interleaved on port %0d", o));
                        end
                    endcase
                end
            end
        end
    end
endmodule

`default_nettype wire

// File: router_two_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "router_defs.svh"

module router_two_stage (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire router_pkg::flit_t    flit_in [`ROUTER_P],
    input  wire logic [`ROUTER_P-1:0] flit_wr_in,
    output router_pkg::flit_t         flit_out [`ROUTER_P],
    output logic [`ROUTER_P-1:0]      flit_wr_out,
    input  wire logic [`ROUTER_V-1:0] credit_in [`ROUTER_P],
    output logic [`ROUTER_V-1:0]      credit_out [`ROUTER_P]
);
    localparam int P = `ROUTER_P;
    localparam int V = `ROUTER_V;

    alloc_if alloc [P] ();
    ovc_if   ovc [P] ();

    router_pkg::flit_t     head_flit [P][V];
    logic [V-1:0]          grant_vc [P];
    logic [P-1:0]          sel_valid;
    router_pkg::port_idx_t sel_port [P];

    for (genvar i = 0; i < P; i++) begin : g_port
        input_port u_in (
            .clk        (clk),
            .arst_n     (arst_n),
            .flit_in    (flit_in[i]),
            .flit_wr_in (flit_wr_in[i]),
            .head_flit  (head_flit[i]),
            .credit_out (credit_out[i]),
            .alloc      (alloc[i])
        );

        // credits from the downstream neighbor on this port
        ovc_status u_ovc (
            .clk       (clk),
            .arst_n    (arst_n),
            .credit_in (credit_in[i]),
            .ovc       (ovc[i])
        );

        assign grant_vc[i] = alloc[i].grant;
    end

    vc_sw_alloc u_alloc (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_ports  (alloc),
        .out_ports (ovc),
        .sel_valid (sel_valid),
        .sel_port  (sel_port)
    );

    crossbar u_xbar (
        .clk         (clk),
        .arst_n      (arst_n),
        .head_flit   (head_flit),
        .grant_vc    (grant_vc),
        .sel_valid   (sel_valid),
        .sel_port    (sel_port),
        .flit_out    (flit_out),
        .flit_wr_out (flit_wr_out)
    );
endmodule

`default_nettype wire

// File: crossbar.sv
`timescale 1ns/1ps
`default_nettype none
`include "router_defs.svh"

module crossbar (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire router_pkg::flit_t     head_flit [`ROUTER_P][`ROUTER_V],
    input  wire logic [`ROUTER_V-1:0]  grant_vc [`ROUTER_P],
    input  wire logic [`ROUTER_P-1:0]  sel_valid,
    input  wire router_pkg::port_idx_t sel_port [`ROUTER_P],
    output router_pkg::flit_t          flit_out [`ROUTER_P],
    output logic [`ROUTER_P-1:0]       flit_wr_out
);
    localparam int P = `ROUTER_P;
    localparam int V = `ROUTER_V;

    router_pkg::flit_t   xbar_flit [P];
    router_pkg::vc_idx_t src_vc [P];

    // granted vc of the selected input
    always_comb begin
        for (int o = 0; o < P; o++) begin
            src_vc[o] = '0;
            for (int v = 0; v < V; v++) begin
                if (grant_vc[sel_port[o]][v]) src_vc[o] = router_pkg::vc_idx_t'(v);
            end
            xbar_flit[o] = head_flit[sel_port[o]][src_vc[o]];
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < P; o++) begin
            if (sel_valid[o]) flit_out[o] <= xbar_flit[o];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) flit_wr_out <= '0;
        else         flit_wr_out <= sel_valid;  // stage 2 strobe
    end
endmodule

`default_nettype wire

// File: vc_sw_alloc.sv
`timescale 1ns/1ps
`default_nettype none
`include "router_defs.svh"

module vc_sw_alloc (
    input  wire logic          clk,
    input  wire logic          arst_n,
    alloc_if.allocator         in_ports [`ROUTER_P],
    ovc_if.allocator           out_ports [`ROUTER_P],
    output logic [`ROUTER_P-1:0] sel_valid,
    output router_pkg::port_idx_t sel_port [`ROUTER_P]
);
    localparam int P = `ROUTER_P;
    localparam int V = `ROUTER_V;

    logic [V-1:0]          req [P];
    logic [V-1:0]          wait_ovc [P];
    logic [V-1:0]          tail [P];
    router_pkg::port_idx_t dest [P][V];
    router_pkg::vc_idx_t   held_ovc [P][V];
    logic [V-1:0]          ovc_free [P];
    logic [V-1:0]          ovc_credit [P];
    logic [V-1:0]          elig [P];
    router_pkg::vc_idx_t   offer [P][V];    // ovc offered to a waiting vc
    logic [V-1:0]          in_gnt [P];      // first level, per input
    router_pkg::vc_idx_t   in_vc [P];
    router_pkg::port_idx_t in_dest [P];
    logic [P-1:0]          out_req [P];
    logic [P-1:0]          out_gnt [P];     // second level, per output
    logic [P-1:0]          in_win;
    router_pkg::vc_idx_t   win_vc [P];

    // eligibility: lowest free ovc with credit, or credit on the held one
    always_comb begin
        for (int i = 0; i < P; i++) begin
            for (int v = 0; v < V; v++) begin
                elig[i][v] = 1'b0;
                offer[i][v] = '0;
                if (req[i][v] && wait_ovc[i][v]) begin
                    for (int k = V - 1; k >= 0; k--) begin
                        if (ovc_free[dest[i][v]][k] && ovc_credit[dest[i][v]][k]) begin
                            elig[i][v] = 1'b1;
                            offer[i][v] = router_pkg::vc_idx_t'(k);
                        end
                    end
                end else if (req[i][v]) begin
                    elig[i][v] = ovc_credit[dest[i][v]][held_ovc[i][v]];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < P; i++) begin
            in_vc[i] = '0;
            for (int v = 0; v < V; v++) begin
                if (in_gnt[i][v]) in_vc[i] = router_pkg::vc_idx_t'(v);
            end
            in_dest[i] = dest[i][in_vc[i]];
        end
        for (int o = 0; o < P; o++) begin
            for (int i = 0; i < P; i++) begin
                out_req[o][i] = (in_gnt[i] != '0) && in_dest[i] == router_pkg::port_idx_t'(o);
            end
        end
    end

    always_comb begin
        for (int o = 0; o < P; o++) begin
            sel_valid[o] = out_gnt[o] != '0;
            sel_port[o] = '0;
            for (int i = 0; i < P; i++) begin
                if (out_gnt[o][i]) sel_port[o] = router_pkg::port_idx_t'(i);
            end
        end
        for (int i = 0; i < P; i++) begin
            in_win[i] = out_gnt[in_dest[i]][i];
        end
    end

    for (genvar i = 0; i < P; i++) begin : g_port
        assign req[i]       = in_ports[i].ivc_req;
        assign wait_ovc[i]  = in_ports[i].ivc_wait_ovc;
        assign tail[i]      = in_ports[i].ivc_tail;
        assign dest[i]      = in_ports[i].ivc_dest;
        assign held_ovc[i]  = in_ports[i].ivc_ovc;
        assign in_ports[i].grant       = in_gnt[i] & {V{in_win[i]}};
        assign in_ports[i].granted_ovc = offer[i];

        assign ovc_free[i]   = out_ports[i].ovc_free;
        assign ovc_credit[i] = out_ports[i].ovc_has_credit;
        assign win_vc[i]     = in_vc[sel_port[i]];
        assign out_ports[i].take_valid = sel_valid[i] && wait_ovc[sel_port[i]][win_vc[i]];
        assign out_ports[i].take_ovc   = offer[sel_port[i]][win_vc[i]];
        assign out_ports[i].send_valid = sel_valid[i];
        assign out_ports[i].send_ovc   = wait_ovc[sel_port[i]][win_vc[i]] ?
                                         offer[sel_port[i]][win_vc[i]] :
                                         held_ovc[sel_port[i]][win_vc[i]];
        assign out_ports[i].send_tail  = tail[sel_port[i]][win_vc[i]];

        // input pointer moves only if the output also picked this input
        rr_arbiter #(.N(V)) u_in_arb (
            .clk(clk), .arst_n(arst_n),
            .req(elig[i]), .advance(in_win[i]), .grant(in_gnt[i])
        );
        rr_arbiter #(.N(P)) u_out_arb (
            .clk(clk), .arst_n(arst_n),
            .req(out_req[i]), .advance(1'b1), .grant(out_gnt[i])
        );
    end
endmodule

`default_nettype wire

// File: ovc_status.sv
`timescale 1ns/1ps
`default_nettype none
`include "router_defs.svh"

module ovc_status (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic [`ROUTER_V-1:0] credit_in,
    ovc_if.status                     ovc
);
    localparam int V = `ROUTER_V;

    logic [V-1:0]            busy;
    router_pkg::credit_cnt_t credits [V];   // free slots downstream
    logic [V-1:0]            dec;

    always_comb begin
        for (int v = 0; v < V; v++) begin
            dec[v] = ovc.send_valid && ovc.send_ovc == router_pkg::vc_idx_t'(v);
            ovc.ovc_free[v] = !busy[v];
            ovc.ovc_has_credit[v] = credits[v] != '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= '0;
            for (int v = 0; v < V; v++) begin
                credits[v] <= router_pkg::credit_cnt_t'(`ROUTER_BUF_DEPTH);
            end
        end else begin
            for (int v = 0; v < V; v++) begin
                if (ovc.take_valid && ovc.take_ovc == router_pkg::vc_idx_t'(v)) begin
                    busy[v] <= 1'b1;
                end
                // single flit claims and releases in one cycle
                if (dec[v] && ovc.send_tail) begin
                    busy[v] <= 1'b0;
                end
                case ({dec[v], credit_in[v]})
                    2'b10:   credits[v] <= credits[v] - 1'b1;
                    2'b01:   credits[v] <= credits[v] + 1'b1;
                    default: credits[v] <= credits[v];  // none, or both cancel
                endcase
            end
        end
    end
endmodule

`default_nettype wire

// File: input_port.sv
`timescale 1ns/1ps
`default_nettype none
`include "router_defs.svh"

module input_port (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire router_pkg::flit_t flit_in,
    input  wire logic              flit_wr_in,
    output router_pkg::flit_t      head_flit [`ROUTER_V],
    output logic [`ROUTER_V-1:0]   credit_out,
    alloc_if.input_port            alloc
);
    localparam int V  = `ROUTER_V;
    localparam int D  = `ROUTER_BUF_DEPTH;
    localparam int AW = $clog2(D);

    router_pkg::flit_t       mem [V][D];
    logic [AW-1:0]           wr_ptr [V];
    logic [AW-1:0]           rd_ptr [V];
    router_pkg::credit_cnt_t count [V];
    router_pkg::ivc_state_e  state [V];
    router_pkg::vc_idx_t     ovc_q [V];     // ovc held until the tail pops
    router_pkg::port_idx_t   dest_q [V];    // route taken from the head
    router_pkg::flit_t       front [V];
    logic [V-1:0]            push;

    always_comb begin
        for (int v = 0; v < V; v++) begin
            push[v] = flit_wr_in && flit_in.vc == router_pkg::vc_idx_t'(v);
            front[v] = mem[v][rd_ptr[v]];
            alloc.ivc_req[v] = count[v] != '0 && state[v] != router_pkg::IVC_IDLE;
            // body and tail flits follow the route of their head
            alloc.ivc_dest[v] = (state[v] == router_pkg::IVC_ACTIVE) ?
                                dest_q[v] : front[v].dest;
            alloc.ivc_wait_ovc[v] = state[v] == router_pkg::IVC_WAIT_OVC;
            alloc.ivc_ovc[v] = ovc_q[v];
            alloc.ivc_tail[v] = front[v].ftype inside {router_pkg::FT_TAIL, router_pkg::FT_SINGLE};
            // outgoing flit carries the output vc, not the input one
            head_flit[v] = front[v];
            head_flit[v].vc = (state[v] == router_pkg::IVC_WAIT_OVC) ?
                              alloc.granted_ovc[v] : ovc_q[v];
        end
    end

    always_ff @(posedge clk) begin
        if (flit_wr_in) begin
            mem[flit_in.vc][wr_ptr[flit_in.vc]] <= flit_in;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_out <= '0;
            for (int v = 0; v < V; v++) begin
                wr_ptr[v] <= '0;
                rd_ptr[v] <= '0;
                count[v] <= '0;
                state[v] <= router_pkg::IVC_IDLE;
                ovc_q[v] <= '0;
                dest_q[v] <= '0;
            end
        end else begin
            credit_out <= alloc.grant;  // one credit back per pop
            for (int v = 0; v < V; v++) begin
                if (push[v]) wr_ptr[v] <= wr_ptr[v] + 1'b1;
                if (alloc.grant[v]) rd_ptr[v] <= rd_ptr[v] + 1'b1;
                case ({push[v], alloc.grant[v]})
                    2'b10:   count[v] <= count[v] + 1'b1;
                    2'b01:   count[v] <= count[v] - 1'b1;
                    default: count[v] <= count[v];
                endcase
                if (state[v] == router_pkg::IVC_IDLE) begin
                    if (push[v]) state[v] <= router_pkg::IVC_WAIT_OVC;
                end else if (alloc.grant[v]) begin
                    if (state[v] == router_pkg::IVC_WAIT_OVC) begin
                        ovc_q[v] <= alloc.granted_ovc[v];
                        dest_q[v] <= front[v].dest;
                    end
                    if (alloc.ivc_tail[v]) begin
                        // next head may already sit behind the tail
                        state[v] <= (count[v] > 1 || push[v]) ?
                                    router_pkg::IVC_WAIT_OVC : router_pkg::IVC_IDLE;
                    end else begin
                        state[v] <= router_pkg::IVC_ACTIVE;
                    end
                end
            end
        end
    end
endmodule

`default_nettype wire

// File: rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
    parameter int N = 4
) (
    input  wire logic         clk,
    input  wire logic         arst_n,
    input  wire logic [N-1:0] req,
    input  wire logic         advance,
    output logic [N-1:0]      grant
);
    localparam int PW = (N > 1) ? $clog2(N) : 1;

    logic [PW-1:0] ptr;     // requester with top priority
    logic [PW-1:0] gidx;
    int unsigned   idx;

    // first requester at or after ptr
    always_comb begin
        grant = '0;
        gidx = '0;
        for (int i = 0; i < N; i++) begin
            idx = (int'(ptr) + i) % N;
            if (req[idx] && grant == '0) begin
                grant[idx] = 1'b1;
                gidx = PW'(idx);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr <= '0;
        end else if (advance && grant != '0) begin
            ptr <= (int'(gidx) == N - 1) ? '0 : gidx + 1'b1;   // step past winner
        end
    end
endmodule

`default_nettype wire

// File: alloc_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "router_defs.svh"

// input port to allocator, one entry per input vc
interface alloc_if;
    logic [`ROUTER_V-1:0]  ivc_req;
    router_pkg::port_idx_t ivc_dest [`ROUTER_V];
    logic [`ROUTER_V-1:0]  ivc_wait_ovc;
    router_pkg::vc_idx_t   ivc_ovc [`ROUTER_V];      // ovc held by an active vc
    logic [`ROUTER_V-1:0]  ivc_tail;
    logic [`ROUTER_V-1:0]  grant;                    // pops the head flit
    router_pkg::vc_idx_t   granted_ovc [`ROUTER_V];

    modport input_port (
        output ivc_req, ivc_dest, ivc_wait_ovc, ivc_ovc, ivc_tail,
        input  grant, granted_ovc
    );
    modport allocator (
        input  ivc_req, ivc_dest, ivc_wait_ovc, ivc_ovc, ivc_tail,
        output grant, granted_ovc
    );
endinterface

// output vc status to allocator, one per output port
interface ovc_if;
    logic [`ROUTER_V-1:0] ovc_free;
    logic [`ROUTER_V-1:0] ovc_has_credit;
    logic                 take_valid;   // ovc claimed by a head
    router_pkg::vc_idx_t  take_ovc;
    logic                 send_valid;
    router_pkg::vc_idx_t  send_ovc;
    logic                 send_tail;

    modport status (
        output ovc_free, ovc_has_credit,
        input  take_valid, take_ovc, send_valid, send_ovc, send_tail
    );
    modport allocator (
        input  ovc_free, ovc_has_credit,
        output take_valid, take_ovc, send_valid, send_ovc, send_tail
    );
endinterface

`default_nettype wire

// File: router_pkg.sv
`default_nettype none
`include "router_defs.svh"

package router_pkg;

    typedef logic [$clog2(`ROUTER_P)-1:0] port_idx_t;
    typedef logic [$clog2(`ROUTER_V)-1:0] vc_idx_t;

    // must reach the full buffer depth
    typedef logic [$clog2(`ROUTER_BUF_DEPTH+1)-1:0] credit_cnt_t;

    typedef enum logic [1:0] {
        FT_HEAD,
        FT_BODY,
        FT_TAIL,
        FT_SINGLE   // head and tail in one flit
    } flit_type_e;

    typedef enum logic [1:0] {
        IVC_IDLE,
        IVC_WAIT_OVC,
        IVC_ACTIVE
    } ivc_state_e;

    typedef struct packed {
        flit_type_e                   ftype;
        vc_idx_t                      vc;
        port_idx_t                    dest;     // look-ahead route, head only
        logic [`ROUTER_PAYLOAD_W-1:0] payload;
    } flit_t;

endpackage

`default_nettype wire

// File: router_defs.svh
`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

`define ROUTER_P          4   // ports
`define ROUTER_V          2   // vcs per port
`define ROUTER_BUF_DEPTH  4   // flits per input vc, power of two
`define ROUTER_PAYLOAD_W  16

`endif
